// File: vlog.f
verilog/rv_isa_pkg.sv
verilog/id_pkg.sv
verilog/gpr_read_if.sv
verilog/id_stage_ctrl.sv
verilog/inst_decoder.sv
verilog/gpr_file.sv
verilog/branch_unit.sv
verilog/id_stage.sv
tests/id_stage_assertions.sv
tests/tb_id_stage.sv

// File: Makefile
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_id_stage: vlog.f $(SRCS)
	verilator --binary -Wno-fatal --assert --top-module tb_id_stage -f vlog.f

run: obj_dir/Vtb_id_stage
	./obj_dir/Vtb_id_stage > sim.log 2>&1; st=$$?; cat sim.log; \
	test $$st -eq 0 && ! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_id_stage.sv
// decode stage testbench with clock, reset, stimulus, reference decode, compare and watchdog
module tb_id_stage;

  localparam int XLEN    = 64;
  localparam int N_RAND  = 400;
  localparam int N_TESTS = N_RAND + 32 + 5;

  typedef struct packed {
    id_pkg::ctrl_t   ctrl;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            taken;
    logic [XLEN-1:0] target;
  } exp_t;

  logic            clk;
  logic            rst_n;
  logic            fs_valid;
  logic [31:0]     fs_inst;
  logic [XLEN-1:0] fs_pc;
  logic            es_allowin;
  logic            wb_wen;
  logic [4:0]      wb_waddr;
  logic [XLEN-1:0] wb_wdata;
  logic [4:0]      es_rd;
  logic [4:0]      ms_rd;
  logic [4:0]      ws_rd;
  logic            ds_allowin;
  logic            es_valid;
  logic [XLEN-1:0] es_rs1_data;
  logic [XLEN-1:0] es_rs2_data;
  logic [XLEN-1:0] es_imm;
  logic [XLEN-1:0] es_pc;
  logic [4:0]      es_rd_out;
  id_pkg::ctrl_t   es_ctrl;
  logic            br_taken;
  logic [XLEN-1:0] br_target;

  logic [XLEN-1:0] shadow [32];  // what the gpr file should hold
  logic [31:0]     q_inst [$];
  logic [XLEN-1:0] q_pc [$];
  logic [31:0]     cur_inst;
  logic [XLEN-1:0] cur_pc;
  exp_t            exp;
  int              n_checks;
  int              n_errors;
  bit              bp_random;

  id_stage #(.XLEN(XLEN)) id_stage_inst (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_fs_valid    (fs_valid),
    .i_fs_inst     (fs_inst),
    .i_fs_pc       (fs_pc),
    .o_ds_allowin  (ds_allowin),
    .i_es_allowin  (es_allowin),
    .o_es_valid    (es_valid),
    .o_es_rs1_data (es_rs1_data),
    .o_es_rs2_data (es_rs2_data),
    .o_es_imm      (es_imm),
    .o_es_pc       (es_pc),
    .o_es_rd       (es_rd_out),
    .o_es_ctrl     (es_ctrl),
    .i_wb_wen      (wb_wen),
    .i_wb_waddr    (wb_waddr),
    .i_wb_wdata    (wb_wdata),
    .i_es_rd       (es_rd),
    .i_ms_rd       (ms_rd),
    .i_ws_rd       (ws_rd),
    .o_br_taken    (br_taken),
    .o_br_target   (br_target)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_ctrl(input string name, input id_pkg::ctrl_t got,
                            input id_pkg::ctrl_t want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("Fail %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("Fail %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("Fail %s got %h expected %h", name, got, want);
    end
  endtask

  function automatic id_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  return id_pkg::ALU_SLL;
      3'b010:  return id_pkg::ALU_SLT;
      3'b011:  return id_pkg::ALU_SLTU;
      3'b100:  return id_pkg::ALU_XOR;
      3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  // expected decode straight from the rv64i encoding rules
  function automatic exp_t ref_decode(input logic [31:0] in, input logic [XLEN-1:0] pc,
                                      input logic [XLEN-1:0] regs [32]);
    exp_t            e;
    id_pkg::ctrl_t   c;
    logic [6:0]      op;
    logic [6:0]      f7;
    logic [2:0]      f3;
    logic [XLEN-1:0] imm;
    logic            ok;
    logic            wr;
    logic            alt;
    logic            cond;
    op  = in[6:0];
    f3  = in[14:12];
    f7  = in[31:25];
    ok  = 1'b1;
    wr  = 1'b0;
    alt = 1'b0;
    imm = '0;
    c   = '0;
    case (op)
      rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: begin
        imm        = {{32{in[31]}}, in[31:12], 12'b0};
        wr         = 1'b1;
        c.src2_sel = id_pkg::SRC2_IMM;
        if (op == rv_isa_pkg::OP_LUI) c.alu_op = id_pkg::ALU_PASS_B;
        else c.src1_sel = id_pkg::SRC1_PC;
      end
      rv_isa_pkg::OP_JAL: begin
        imm        = {{44{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
        wr         = 1'b1;
        c.is_jal   = 1'b1;
        c.src1_sel = id_pkg::SRC1_PC;
      end
      rv_isa_pkg::OP_JALR: begin
        imm        = {{52{in[31]}}, in[31:20]};
        wr         = 1'b1;
        ok         = (f3 == 3'b000);
        c.is_jalr  = 1'b1;
        c.src1_sel = id_pkg::SRC1_PC;
      end
      rv_isa_pkg::OP_BRANCH: begin
        imm         = {{52{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
        ok          = (f3 != 3'b010) && (f3 != 3'b011);
        c.is_branch = 1'b1;
      end
      rv_isa_pkg::OP_LOAD: begin  // lb..ld, lbu..lwu
        imm        = {{52{in[31]}}, in[31:20]};
        wr         = 1'b1;
        ok         = (f3 != 3'b111);
        c.mem_ren  = 1'b1;
        c.mem_op   = f3;
        c.src2_sel = id_pkg::SRC2_IMM;
      end
      rv_isa_pkg::OP_STORE: begin
        imm        = {{52{in[31]}}, in[31:25], in[11:7]};
        ok         = (f3 < 3'd4);
        c.mem_wen  = 1'b1;
        c.mem_op   = f3;
        c.src2_sel = id_pkg::SRC2_IMM;
      end
      rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM32: begin
        imm        = {{52{in[31]}}, in[31:20]};
        wr         = 1'b1;
        c.word_op  = (op == rv_isa_pkg::OP_IMM32);
        c.src2_sel = id_pkg::SRC2_IMM;
        alt        = (f3 == 3'b101) && f7[5];
        if (f3 == 3'b001) ok = c.word_op ? (f7 == 7'h00) : (f7[6:1] == 6'h0);
        else if (f3 == 3'b101) ok = c.word_op ? (f7 == 7'h00 || f7 == 7'h20)
                                              : (f7[6] == 1'b0 && f7[4:1] == 4'h0);
        else if (c.word_op) ok = (f3 == 3'b000);
        c.alu_op   = alu_of(f3, alt);
      end
      rv_isa_pkg::OP_OP, rv_isa_pkg::OP_OP32: begin
        wr        = 1'b1;
        c.word_op = (op == rv_isa_pkg::OP_OP32);
        alt       = (f7 == 7'h20);
        ok        = (f7 == 7'h00) || (alt && (f3 == 3'b000 || f3 == 3'b101));
        if (c.word_op && !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101)) ok = 1'b0;
        c.alu_op  = alu_of(f3, alt);
      end
      default: ok = 1'b0;
    endcase
    c.gpr_wen = wr && (in[11:7] != 5'd0);
    if (!ok) begin
      c         = '0;
      c.invalid = 1'b1;
    end
    e.ctrl = c;
    e.rd   = c.gpr_wen ? in[11:7] : 5'd0;
    e.imm  = imm;
    e.rs1  = regs[in[19:15]];
    e.rs2  = regs[in[24:20]];
    case (f3)
      3'b000:  cond = (e.rs1 == e.rs2);
      3'b001:  cond = (e.rs1 != e.rs2);
      3'b100:  cond = ($signed(e.rs1) < $signed(e.rs2));
      3'b101:  cond = ($signed(e.rs1) >= $signed(e.rs2));
      3'b110:  cond = (e.rs1 < e.rs2);
      default: cond = (e.rs1 >= e.rs2);
    endcase
    e.taken  = c.is_jal || c.is_jalr || (c.is_branch && cond);
    e.target = c.is_jalr ? ((e.rs1 + imm) & ~64'd1) : pc + imm;
    return e;
  endfunction

  function automatic logic [31:0] rand_inst();
    logic [31:0] w;
    logic [6:0]  op;
    w = $urandom;
    case ($urandom_range(0, 12))
      0:       op = rv_isa_pkg::OP_LUI;
      1:       op = rv_isa_pkg::OP_AUIPC;
      2:       op = rv_isa_pkg::OP_JAL;
      3:       op = rv_isa_pkg::OP_JALR;
      4:       op = rv_isa_pkg::OP_BRANCH;
      5:       op = rv_isa_pkg::OP_LOAD;
      6:       op = rv_isa_pkg::OP_STORE;
      7:       op = rv_isa_pkg::OP_IMM;
      8:       op = rv_isa_pkg::OP_OP;
      9:       op = rv_isa_pkg::OP_IMM32;
      10:      op = rv_isa_pkg::OP_OP32;
      11:      op = 7'b1110011;  // system
      default: op = 7'(w[6:0] | 7'b0000100);  // mostly unknown
    endcase
    // bias funct7 to legal values most of the time
    if (op == rv_isa_pkg::OP_OP || op == rv_isa_pkg::OP_OP32 || op == rv_isa_pkg::OP_IMM32
        || (op == rv_isa_pkg::OP_IMM && w[13:12] == 2'b01)) begin
      if ($urandom_range(0, 7) < 4) w[31:26] = 6'h00;
      else if ($urandom_range(0, 3) != 0) w[31:26] = 6'h10;
      if (op != rv_isa_pkg::OP_IMM) w[25] = ($urandom_range(0, 7) == 0);
    end
    return {w[31:7], op};
  endfunction

  task automatic send_inst(input logic [31:0] inst, input logic [XLEN-1:0] pc);
    @(negedge clk);
    fs_valid = 1'b1;
    fs_inst  = inst;
    fs_pc    = pc;
    @(posedge clk);
    while (!ds_allowin) @(posedge clk);
  endtask

  task automatic go_idle();
    @(negedge clk);
    fs_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (q_inst.size() != 0) @(negedge clk);
  endtask

  // one instruction against downstream destinations
  task automatic stall_case(input logic [31:0] inst, input logic [4:0] es,
                            input logic [4:0] ms, input logic [4:0] ws, input logic stall);
    wait_drain();
    @(negedge clk);
    es_rd = es;
    ms_rd = ms;
    ws_rd = ws;
    send_inst(inst, 64'h8000_1000);
    go_idle();
    check_bit("o_es_valid", es_valid, !stall);
    if (stall) begin
      repeat (3) begin
        @(negedge clk);
        check_bit("o_es_valid", es_valid, 1'b0);
        check_bit("o_ds_allowin", ds_allowin, 1'b0);
      end
      es_rd = 5'd0;
      ms_rd = 5'd0;
      ws_rd = 5'd0;
    end
    wait_drain();
  endtask

  // accept and compare on the edge the dut sees
  always @(posedge clk) begin
    if (rst_n && es_valid && es_allowin) begin
      if (q_inst.size() == 0) begin
        n_errors++;
        $display("an instruction left the stage that was never accepted");
      end else begin
        cur_inst = q_inst.pop_front();
        cur_pc   = q_pc.pop_front();
        exp      = ref_decode(cur_inst, cur_pc, shadow);
        check_ctrl("o_es_ctrl", es_ctrl, exp.ctrl);
        check_data("o_es_rd", XLEN'(es_rd_out), XLEN'(exp.rd));
        check_data("o_es_imm", es_imm, exp.imm);
        check_data("o_es_pc", es_pc, cur_pc);
        check_data("o_es_rs1_data", es_rs1_data, exp.rs1);
        check_data("o_es_rs2_data", es_rs2_data, exp.rs2);
        check_bit("o_br_taken", br_taken, exp.taken);
        check_data("o_br_target", br_target, exp.target);
      end
    end
    if (rst_n && fs_valid && ds_allowin) begin
      q_inst.push_back(fs_inst);
      q_pc.push_back(fs_pc);
    end
  end

  always @(negedge clk) begin
    if (bp_random) es_allowin = ($urandom_range(0, 3) != 0);
  end

  initial begin
    #(N_TESTS * 40 * 20);
    $display("timeout, the stage stopped making progress");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h7f77e0ba));
    rst_n      = 1'b0;
    fs_valid   = 1'b0;
    fs_inst    = '0;
    fs_pc      = '0;
    es_allowin = 1'b1;
    wb_wen     = 1'b0;
    wb_waddr   = '0;
    wb_wdata   = '0;
    es_rd      = '0;
    ms_rd      = '0;
    ws_rd      = '0;
    bp_random  = 1'b0;
    n_checks   = 0;
    n_errors   = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // write every register including x0
    for (int i = 0; i < 32; i++) begin
      @(negedge clk);
      wb_wen    = 1'b1;
      wb_waddr  = 5'(i);
      wb_wdata  = {$urandom, $urandom};
      shadow[i] = (i == 0) ? '0 : wb_wdata;
    end
    @(negedge clk);
    wb_wen = 1'b0;
    for (int i = 0; i < 32; i++) begin
      send_inst({7'h00, 5'(31 - i), 5'(i), 3'b000, 5'd1, rv_isa_pkg::OP_OP}, 64'h1000);
    end
    go_idle();
    wait_drain();

    bp_random = 1'b1;
    repeat (N_RAND) begin
      send_inst(rand_inst(), {$urandom, $urandom} & ~64'd3);
      if ($urandom_range(0, 7) == 0) go_idle();
    end
    go_idle();
    wait_drain();
    bp_random  = 1'b0;
    @(negedge clk);
    es_allowin = 1'b1;

    // add x3,x5,x6 / addi x3,x5,6 / add x3,x0,x7
    stall_case(32'h006281b3, 5'd5, 5'd0, 5'd0, 1'b1);
    stall_case(32'h006281b3, 5'd0, 5'd6, 5'd0, 1'b1);
    stall_case(32'h006281b3, 5'd0, 5'd0, 5'd5, 1'b1);
    stall_case(32'h00628193, 5'd6, 5'd0, 5'd0, 1'b0);  // rs2 field unused
    stall_case(32'h007001b3, 5'd0, 5'd0, 5'd0, 1'b0);

    repeat (2) @(posedge clk);
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: tests/id_stage_assertions.sv
// bound checks on decode stage handshake, redirect and held outputs
module id_stage_assertions #(
  parameter int XLEN = 64
) (
  input logic                              i_clk,
  input logic                              i_rst_n,
  input logic                              i_es_allowin,
  input logic                              o_es_valid,
  input logic [XLEN-1:0]                   o_es_pc,
  input logic [XLEN-1:0]                   o_es_imm,
  input logic [rv_isa_pkg::GPR_ADDR_W-1:0] o_es_rd,
  input id_pkg::ctrl_t                     o_es_ctrl,
  input logic                              o_br_taken,
  input logic [XLEN-1:0]                   o_br_target
);

  // stage comes out of reset empty
  a_empty_after_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_es_valid)
    else $error("stage valid after reset");

  a_redirect_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_br_taken |-> o_es_valid)
    else $error("branch taken without a valid instruction");

  // execute not ready, everything held
  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_es_valid && !i_es_allowin |=> o_es_valid && $stable(o_es_pc) && $stable(o_es_imm)
      && $stable(o_es_rd) && $stable(o_es_ctrl) && $stable(o_br_taken)
      && $stable(o_br_target))
    else $error("outputs changed under back-pressure");

endmodule

bind id_stage id_stage_assertions #(.XLEN(XLEN)) u_assertions (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_es_allowin (i_es_allowin),
  .o_es_valid   (o_es_valid),
  .o_es_pc      (o_es_pc),
  .o_es_imm     (o_es_imm),
  .o_es_rd      (o_es_rd),
  .o_es_ctrl    (o_es_ctrl),
  .o_br_taken   (o_br_taken),
  .o_br_target  (o_br_target)
);

// File: verilog/id_stage.sv
// decode stage top: stage control, decoder, register file and branch unit
module id_stage #(
  parameter int XLEN = 64
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  // fetch handshake
  input  logic                              i_fs_valid,
  input  logic [31:0]                       i_fs_inst,
  input  logic [XLEN-1:0]                   i_fs_pc,
  output logic                              o_ds_allowin,
  // execute handshake
  input  logic                              i_es_allowin,
  output logic                              o_es_valid,
  output logic [XLEN-1:0]                   o_es_rs1_data,
  output logic [XLEN-1:0]                   o_es_rs2_data,
  output logic [XLEN-1:0]                   o_es_imm,
  output logic [XLEN-1:0]                   o_es_pc,
  output logic [rv_isa_pkg::GPR_ADDR_W-1:0] o_es_rd,
  output id_pkg::ctrl_t                     o_es_ctrl,
  // write back
  input  logic                              i_wb_wen,
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_wb_waddr,
  input  logic [XLEN-1:0]                   i_wb_wdata,
  // hazard sources
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_es_rd,
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_ms_rd,
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_ws_rd,
  // redirect to fetch
  output logic                              o_br_taken,
  output logic [XLEN-1:0]                   o_br_target
);

  rv_isa_pkg::inst_u ds_inst;
  logic              rs1_used;
  logic              rs2_used;

  gpr_read_if #(.XLEN(XLEN)) gpr_rd ();

  assign o_es_rs1_data = gpr_rd.rs1_data;
  assign o_es_rs2_data = gpr_rd.rs2_data;

  id_stage_ctrl #(.XLEN(XLEN)) u_ctrl (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_fs_valid   (i_fs_valid),
    .i_fs_inst    (i_fs_inst),
    .i_fs_pc      (i_fs_pc),
    .o_ds_allowin (o_ds_allowin),
    .i_es_allowin (i_es_allowin),
    .o_es_valid   (o_es_valid),
    .i_es_rd      (i_es_rd),
    .i_ms_rd      (i_ms_rd),
    .i_ws_rd      (i_ws_rd),
    .i_rs1_addr   (gpr_rd.rs1_addr),
    .i_rs2_addr   (gpr_rd.rs2_addr),
    .i_rs1_used   (rs1_used),
    .i_rs2_used   (rs2_used),
    .o_inst       (ds_inst),
    .o_pc         (o_es_pc)
  );

  inst_decoder #(.XLEN(XLEN)) u_dec (
    .i_inst     (ds_inst),
    .rd_if      (gpr_rd),
    .o_rd       (o_es_rd),
    .o_imm      (o_es_imm),
    .o_ctrl     (o_es_ctrl),
    .o_rs1_used (rs1_used),
    .o_rs2_used (rs2_used)
  );

  gpr_file #(.XLEN(XLEN)) u_gpr (
    .i_clk   (i_clk),
    .i_wen   (i_wb_wen),
    .i_waddr (i_wb_waddr),
    .i_wdata (i_wb_wdata),
    .rd_if   (gpr_rd)
  );

  branch_unit #(.XLEN(XLEN)) u_bru (
    .i_valid     (o_es_valid),  // no redirect while stalled
    .i_ctrl      (o_es_ctrl),
    .i_funct3    (ds_inst.b.funct3),
    .i_pc        (o_es_pc),
    .i_rs1_data  (gpr_rd.rs1_data),
    .i_imm       (o_es_imm),
    .rd_if       (gpr_rd),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

// File: verilog/branch_unit.sv
// branch condition and jump target evaluation, redirect to fetch
module branch_unit #(
  parameter int XLEN = 64
) (
  input  logic            i_valid,
  input  id_pkg::ctrl_t   i_ctrl,
  input  logic [2:0]      i_funct3,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_imm,
  gpr_read_if.decoder     rd_if,      // only rs2_data is read here
  output logic            o_br_taken,
  output logic [XLEN-1:0] o_br_target
);

  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] jalr_sum;
  logic            cond;

  assign rs2_data = rd_if.rs2_data;

  always_comb begin
    case (i_funct3)
      rv_isa_pkg::F3_BEQ:  cond = (i_rs1_data == rs2_data);
      rv_isa_pkg::F3_BNE:  cond = (i_rs1_data != rs2_data);
      rv_isa_pkg::F3_BLT:  cond = ($signed(i_rs1_data) < $signed(rs2_data));
      rv_isa_pkg::F3_BGE:  cond = ($signed(i_rs1_data) >= $signed(rs2_data));
      rv_isa_pkg::F3_BLTU: cond = (i_rs1_data < rs2_data);
      rv_isa_pkg::F3_BGEU: cond = (i_rs1_data >= rs2_data);
      default:             cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  // jalr clears bit 0, branches and jal are pc relative
  assign o_br_target = i_ctrl.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;

  assign o_br_taken = i_valid
                   && (i_ctrl.is_jal || i_ctrl.is_jalr || (i_ctrl.is_branch && cond));

endmodule

// File: verilog/gpr_file.sv
// 32-entry general register file, two async reads, one write, x0 hardwired
module gpr_file #(
  parameter int XLEN = 64
) (
  input  logic                              i_clk,
  input  logic                              i_wen,
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_waddr,
  input  logic [XLEN-1:0]                   i_wdata,
  gpr_read_if.regfile                       rd_if
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, a same-cycle write shows up next cycle
  assign rd_if.rs1_data = (rd_if.rs1_addr == '0) ? '0 : regs[rd_if.rs1_addr];
  assign rd_if.rs2_data = (rd_if.rs2_addr == '0) ? '0 : regs[rd_if.rs2_addr];

endmodule

// File: verilog/inst_decoder.sv
// rv64i instruction decoder: register indices, immediate and control
module inst_decoder #(
  parameter int XLEN = 64
) (
  input  rv_isa_pkg::inst_u                 i_inst,
  gpr_read_if.decoder                       rd_if,
  output logic [rv_isa_pkg::GPR_ADDR_W-1:0] o_rd,
  output logic [XLEN-1:0]                   o_imm,
  output id_pkg::ctrl_t                     o_ctrl,
  output logic                              o_rs1_used,
  output logic                              o_rs2_used
);

  logic [6:0]        op;
  logic [2:0]        f3;
  logic [6:0]        f7;
  logic signed [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic signed [31:0] imm32;
  logic              ok;
  logic              wr;
  logic              alt;

  function automatic id_pkg::alu_op_e alu_sel(input logic [2:0] funct3, input logic sub_sra);
    case (funct3)
      rv_isa_pkg::F3_ADD_SUB: return sub_sra ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     return id_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     return id_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    return id_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     return id_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: return sub_sra ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      return id_pkg::ALU_OR;
      default:                return id_pkg::ALU_AND;
    endcase
  endfunction

  assign op = i_inst.r.opcode;
  assign f3 = i_inst.r.funct3;
  assign f7 = i_inst.r.funct7;

  assign imm_i = {{20{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
  assign imm_s = {{20{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
  assign imm_b = {{20{i_inst.b.imm_12}}, i_inst.b.imm_11, i_inst.b.imm_10_5,
                  i_inst.b.imm_4_1, 1'b0};
  assign imm_u = {i_inst.u.imm_31_12, 12'b0};
  assign imm_j = {{12{i_inst.j.imm_20}}, i_inst.j.imm_19_12, i_inst.j.imm_11,
                  i_inst.j.imm_10_1, 1'b0};

  // index fields sit at the same place in every format
  assign rd_if.rs1_addr = i_inst.r.rs1;
  assign rd_if.rs2_addr = i_inst.r.rs2;

  always_comb begin
    ok         = 1'b1;
    wr         = 1'b0;
    alt        = 1'b0;
    imm32      = '0;
    o_ctrl     = '0;
    o_rs1_used = 1'b0;
    o_rs2_used = 1'b0;
    case (op)
      rv_isa_pkg::OP_LUI: begin
        imm32           = imm_u;
        wr              = 1'b1;
        o_ctrl.alu_op   = id_pkg::ALU_PASS_B;
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
      end
      rv_isa_pkg::OP_AUIPC: begin
        imm32           = imm_u;
        wr              = 1'b1;
        o_ctrl.src1_sel = id_pkg::SRC1_PC;
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
      end
      rv_isa_pkg::OP_JAL: begin  // link value pc+4 is made in execute
        imm32           = imm_j;
        wr              = 1'b1;
        o_ctrl.is_jal   = 1'b1;
        o_ctrl.src1_sel = id_pkg::SRC1_PC;
      end
      rv_isa_pkg::OP_JALR: begin
        imm32          = imm_i;
        wr             = 1'b1;
        ok             = (f3 == 3'b000);
        o_rs1_used     = 1'b1;
        o_ctrl.is_jalr = 1'b1;
        o_ctrl.src1_sel = id_pkg::SRC1_PC;
      end
      rv_isa_pkg::OP_BRANCH: begin
        imm32            = imm_b;
        ok               = (f3 != 3'b010) && (f3 != 3'b011);
        o_rs1_used       = 1'b1;
        o_rs2_used       = 1'b1;
        o_ctrl.is_branch = 1'b1;
      end
      rv_isa_pkg::OP_LOAD: begin
        imm32           = imm_i;
        wr              = 1'b1;
        ok              = (f3 != 3'b111);
        o_rs1_used      = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.mem_op   = f3;
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
      end
      rv_isa_pkg::OP_STORE: begin
        imm32           = imm_s;
        ok              = !f3[2];  // sb..sd
        o_rs1_used      = 1'b1;
        o_rs2_used      = 1'b1;
        o_ctrl.mem_wen  = 1'b1;
        o_ctrl.mem_op   = f3;
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
      end
      rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM32: begin
        imm32           = imm_i;
        wr              = 1'b1;
        o_rs1_used      = 1'b1;
        o_ctrl.word_op  = (op == rv_isa_pkg::OP_IMM32);
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
        alt             = (f3 == rv_isa_pkg::F3_SRL_SRA) && f7[5];
        if (f3 == rv_isa_pkg::F3_SLL) begin
          ok = o_ctrl.word_op ? (f7 == rv_isa_pkg::F7_BASE) : (f7[6:1] == '0);
        end else if (f3 == rv_isa_pkg::F3_SRL_SRA) begin
          ok = o_ctrl.word_op ? (f7 == rv_isa_pkg::F7_BASE || f7 == rv_isa_pkg::F7_ALT)
                              : (!f7[6] && f7[4:1] == '0);  // 6-bit shamt
        end else if (o_ctrl.word_op) begin
          ok = (f3 == rv_isa_pkg::F3_ADD_SUB);
        end
        o_ctrl.alu_op = alu_sel(f3, alt);
      end
      rv_isa_pkg::OP_OP, rv_isa_pkg::OP_OP32: begin
        wr             = 1'b1;
        o_rs1_used     = 1'b1;
        o_rs2_used     = 1'b1;
        o_ctrl.word_op = (op == rv_isa_pkg::OP_OP32);
        alt            = (f7 == rv_isa_pkg::F7_ALT);
        ok = (f7 == rv_isa_pkg::F7_BASE)
          || (alt && (f3 == rv_isa_pkg::F3_ADD_SUB || f3 == rv_isa_pkg::F3_SRL_SRA));
        if (o_ctrl.word_op && !(f3 == rv_isa_pkg::F3_ADD_SUB || f3 == rv_isa_pkg::F3_SLL
                                || f3 == rv_isa_pkg::F3_SRL_SRA)) begin
          ok = 1'b0;
        end
        o_ctrl.alu_op = alu_sel(f3, alt);
      end
      default: ok = 1'b0;  // system and anything unknown
    endcase
    o_ctrl.gpr_wen = wr && (i_inst.r.rd != '0);
    if (!ok) begin
      o_ctrl         = '0;
      o_ctrl.invalid = 1'b1;
      o_rs1_used     = 1'b0;
      o_rs2_used     = 1'b0;
    end
  end

  // rd reads as x0 when nothing is written back
  assign o_rd  = o_ctrl.gpr_wen ? i_inst.r.rd : '0;
  assign o_imm = XLEN'(imm32);

endmodule

// File: verilog/id_stage_ctrl.sv
// decode stage valid/instruction/pc registers, hazard stall and allowin
module id_stage_ctrl #(
  parameter int XLEN = 64
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  // from fetch
  input  logic                              i_fs_valid,
  input  rv_isa_pkg::inst_u                 i_fs_inst,
  input  logic [XLEN-1:0]                   i_fs_pc,
  output logic                              o_ds_allowin,
  // to execute
  input  logic                              i_es_allowin,
  output logic                              o_es_valid,
  // destinations still in flight downstream
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_es_rd,
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_ms_rd,
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_ws_rd,
  // sources of the held instruction
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_rs1_addr,
  input  logic [rv_isa_pkg::GPR_ADDR_W-1:0] i_rs2_addr,
  input  logic                              i_rs1_used,
  input  logic                              i_rs2_used,
  output rv_isa_pkg::inst_u                 o_inst,
  output logic [XLEN-1:0]                   o_pc
);

  logic ds_valid;
  logic ds_ready_go;
  logic hazard;

  // one downstream destination against both used sources
  function automatic logic dst_conflict(
    input logic [rv_isa_pkg::GPR_ADDR_W-1:0] dst,
    input logic [rv_isa_pkg::GPR_ADDR_W-1:0] rs1,
    input logic [rv_isa_pkg::GPR_ADDR_W-1:0] rs2,
    input logic                              use1,
    input logic                              use2
  );
    return (dst != '0) && ((use1 && dst == rs1) || (use2 && dst == rs2));
  endfunction

  // no forwarding, wait until the writer has retired
  assign hazard = dst_conflict(i_es_rd, i_rs1_addr, i_rs2_addr, i_rs1_used, i_rs2_used)
               || dst_conflict(i_ms_rd, i_rs1_addr, i_rs2_addr, i_rs1_used, i_rs2_used)
               || dst_conflict(i_ws_rd, i_rs1_addr, i_rs2_addr, i_rs1_used, i_rs2_used);

  assign ds_ready_go  = !hazard;
  assign o_ds_allowin = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_es_valid   = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin  // accept from fetch
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

// File: verilog/gpr_read_if.sv
// register file read ports, decoder and regfile views
interface gpr_read_if #(
  parameter int XLEN = 64
);

  logic [rv_isa_pkg::GPR_ADDR_W-1:0] rs1_addr;
  logic [rv_isa_pkg::GPR_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]                   rs1_data;
  logic [XLEN-1:0]                   rs2_data;

  modport decoder (
    output rs1_addr,
    output rs2_addr,
    input  rs1_data,
    input  rs2_data
  );

  // reads are combinational
  modport regfile (
    input  rs1_addr,
    input  rs2_addr,
    output rs1_data,
    output rs2_data
  );

endinterface

// File: verilog/id_pkg.sv
// decode control types handed from decode to execute
package id_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1,
    SRC1_PC
  } src1_sel_e;

  typedef enum logic {
    SRC2_RS2,
    SRC2_IMM
  } src2_sel_e;

  typedef struct packed {
    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic      word_op;   // *w forms, 32-bit result sign extended
    logic      gpr_wen;
    logic      mem_ren;
    logic      mem_wen;
    logic [2:0] mem_op;   // funct3 of load/store, size and sign
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      invalid;
  } ctrl_t;

endpackage

// File: verilog/rv_isa_pkg.sv
// rv64i opcodes, funct constants, instruction format structs and instruction union
package rv_isa_pkg;

  parameter int GPR_ADDR_W = 5;

  // major opcodes of the supported groups
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_IMM32  = 7'b0011011,
    OP_OP32   = 7'b0111011
  } opcode_e;

  // branch conditions
  parameter logic [2:0] F3_BEQ  = 3'b000;
  parameter logic [2:0] F3_BNE  = 3'b001;
  parameter logic [2:0] F3_BLT  = 3'b100;
  parameter logic [2:0] F3_BGE  = 3'b101;
  parameter logic [2:0] F3_BLTU = 3'b110;
  parameter logic [2:0] F3_BGEU = 3'b111;

  // alu groups, shared by OP, OP-IMM and the word forms
  parameter logic [2:0] F3_ADD_SUB = 3'b000;
  parameter logic [2:0] F3_SLL     = 3'b001;
  parameter logic [2:0] F3_SLT     = 3'b010;
  parameter logic [2:0] F3_SLTU    = 3'b011;
  parameter logic [2:0] F3_XOR     = 3'b100;
  parameter logic [2:0] F3_SRL_SRA = 3'b101;
  parameter logic [2:0] F3_OR      = 3'b110;
  parameter logic [2:0] F3_AND     = 3'b111;

  parameter logic [6:0] F7_BASE = 7'b0000000;
  parameter logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

  typedef struct packed {
    logic [6:0]            funct7;
    logic [GPR_ADDR_W-1:0] rs2;
    logic [GPR_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [GPR_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm_11_0;
    logic [GPR_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [GPR_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_11_5;
    logic [GPR_ADDR_W-1:0] rs2;
    logic [GPR_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_4_0;
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [GPR_ADDR_W-1:0] rs2;
    logic [GPR_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    logic [6:0]            opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]           imm_31_12;
    logic [GPR_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [GPR_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } j_fmt_t;

  // one 32-bit word, six views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage
